//--- hw/jtag_pkg.sv
package jtag_pkg;

	// 1149.1 controller states with the usual 4-bit encodings
	typedef enum logic [3:0] {
		exit2_dr         = 4'h0,
		exit1_dr         = 4'h1,
		shift_dr         = 4'h2,
		pause_dr         = 4'h3,
		select_ir_scan   = 4'h4,
		update_dr        = 4'h5,
		capture_dr       = 4'h6,
		select_dr_scan   = 4'h7,
		exit2_ir         = 4'h8,
		exit1_ir         = 4'h9,
		shift_ir         = 4'hA,
		pause_ir         = 4'hB,
		run_test_idle    = 4'hC,
		update_ir        = 4'hD,
		capture_ir       = 4'hE,
		test_logic_reset = 4'hF
	} tap_state_t;

	// low-level commands of the master
	typedef enum logic [1:0] {
		cmd_bus_reset = 2'd0,
		cmd_scan_ir   = 2'd1,
		cmd_scan_dr   = 2'd2
	} jtag_cmd_t;

	localparam int SCAN_W = 32;    // drive, expect, mask and capture width

	// tap clocks with trst low and tms high during bus reset
	localparam int RESET_TCKS = 5;

endpackage

//--- hw/tck_gen.sv
`timescale 1ns/1ps

module tck_gen #(
	parameter int TCK_DIV = 2    // tck_1 cycles per half tap clock
) (
	input  logic tck_1,
	input  logic reset,
	input  logic run,
	output logic tap_tck,
	output logic tck_rise,
	output logic tck_fall
);

	localparam int CNT_W = (TCK_DIV > 1) ? $clog2(TCK_DIV) : 1;

	logic [CNT_W-1:0] cnt;
	logic             term;

	assign term = (cnt == CNT_W'(TCK_DIV - 1));

	// strobes lead the edge of tap_tck by one tck_1 cycle
	assign tck_rise = run & ~tap_tck & term;
	assign tck_fall = run & tap_tck & term;

	always_ff @(posedge tck_1) begin
		if (!reset) begin
			cnt     <= '0;
			tap_tck <= 1'b0;
		end else if (!run) begin
			cnt     <= '0;
			tap_tck <= 1'b0;    // park low, cut a pending high phase short
		end else if (term) begin
			cnt     <= '0;
			tap_tck <= ~tap_tck;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- hw/tap_state_tracker.sv
`timescale 1ns/1ps

module tap_state_tracker (
	input  logic                 tck_1,
	input  logic                 reset,
	input  logic                 tck_rise,
	input  logic                 tms,
	output jtag_pkg::tap_state_t state
);

	////////////////////////////////////////////////////////////////////////////
	// 1149.1 state graph, one step per tap clock rise
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge tck_1) begin
		if (!reset) begin
			state <= jtag_pkg::test_logic_reset;
		end else if (tck_rise) begin
			case (state)
				jtag_pkg::test_logic_reset:
					state <= tms ? jtag_pkg::test_logic_reset : jtag_pkg::run_test_idle;
				jtag_pkg::run_test_idle:
					state <= tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
				jtag_pkg::select_dr_scan:
					state <= tms ? jtag_pkg::select_ir_scan : jtag_pkg::capture_dr;
				jtag_pkg::select_ir_scan:
					state <= tms ? jtag_pkg::test_logic_reset : jtag_pkg::capture_ir;

				// dr column
				jtag_pkg::capture_dr: state <= tms ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
				jtag_pkg::shift_dr:   state <= tms ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
				jtag_pkg::exit1_dr:   state <= tms ? jtag_pkg::update_dr : jtag_pkg::pause_dr;
				jtag_pkg::pause_dr:   state <= tms ? jtag_pkg::exit2_dr : jtag_pkg::pause_dr;
				jtag_pkg::exit2_dr:   state <= tms ? jtag_pkg::update_dr : jtag_pkg::shift_dr;
				jtag_pkg::update_dr:
					state <= tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;

				// ir column
				jtag_pkg::capture_ir: state <= tms ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
				jtag_pkg::shift_ir:   state <= tms ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
				jtag_pkg::exit1_ir:   state <= tms ? jtag_pkg::update_ir : jtag_pkg::pause_ir;
				jtag_pkg::pause_ir:   state <= tms ? jtag_pkg::exit2_ir : jtag_pkg::pause_ir;
				jtag_pkg::exit2_ir:   state <= tms ? jtag_pkg::update_ir : jtag_pkg::shift_ir;
				jtag_pkg::update_ir:
					state <= tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;

				default: state <= jtag_pkg::test_logic_reset;
			endcase
		end
	end

endmodule

//--- hw/tap_sequencer.sv
`timescale 1ns/1ps

module tap_sequencer (
	input  logic                 tck_1,
	input  logic                 reset,
	input  logic                 cmd_start,
	input  jtag_pkg::jtag_cmd_t  cmd,
	input  logic [5:0]           scan_len,
	input  logic                 tck_fall,
	input  jtag_pkg::tap_state_t state,
	output logic                 run,
	output logic                 tms,
	output logic                 trst_n,
	output logic                 shift_en,
	output logic                 start_load,
	output logic                 busy,
	output logic                 done
);

	typedef enum logic [1:0] {
		seq_idle,
		seq_reset,
		seq_scan
	} seq_state_t;

	seq_state_t          seq;
	jtag_pkg::jtag_cmd_t cmd_q;
	logic [5:0]          len_q;
	logic [5:0]          cnt;      // reset clocks or shift bits so far
	logic                fin;      // last transition toward idle issued
	logic                in_shift;
	logic                last_bit;

	// tms for the next rise, seen from the tracked state
	function automatic logic scan_tms(jtag_pkg::tap_state_t s, logic ir, logic last);
		case (s)
			jtag_pkg::test_logic_reset:            return 1'b0;
			jtag_pkg::run_test_idle:               return 1'b1;
			jtag_pkg::select_dr_scan:              return ir;    // on to select-ir
			jtag_pkg::select_ir_scan:              return 1'b0;
			jtag_pkg::capture_dr, jtag_pkg::capture_ir: return 1'b0;
			jtag_pkg::shift_dr, jtag_pkg::shift_ir:     return last;
			jtag_pkg::update_dr, jtag_pkg::update_ir:   return 1'b0;
			default:                               return 1'b1; // exit and pause
		endcase
	endfunction

	assign in_shift   = (state == jtag_pkg::shift_ir) || (state == jtag_pkg::shift_dr);
	assign last_bit   = (cnt == len_q - 6'd1);
	assign shift_en   = (seq == seq_scan) && in_shift;
	assign start_load = cmd_start & ~busy;

	////////////////////////////////////////////////////////////////////////////
	// command fsm
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge tck_1) begin
		if (!reset) begin
			seq    <= seq_idle;
			busy   <= 1'b0;
			done   <= 1'b0;
			run    <= 1'b0;
			tms    <= 1'b1;
			trst_n <= 1'b1;
			fin    <= 1'b0;
			cnt    <= '0;
		end else begin
			done <= 1'b0;
			if (seq != seq_idle && fin && state == jtag_pkg::run_test_idle) begin
				seq  <= seq_idle;    // back in run-test/idle
				busy <= 1'b0;
				run  <= 1'b0;
				done <= 1'b1;
			end else begin
				case (seq)
					seq_idle: begin
						if (start_load) begin
							busy  <= 1'b1;
							run   <= 1'b1;
							cmd_q <= cmd;
							len_q <= scan_len;
							cnt   <= '0;
							fin   <= 1'b0;
							if (cmd == jtag_pkg::cmd_bus_reset) begin
								seq    <= seq_reset;
								trst_n <= 1'b0;
								tms    <= 1'b1;
							end else begin
								seq <= seq_scan;
								tms <= scan_tms(state, cmd == jtag_pkg::cmd_scan_ir, 1'b0);
							end
						end
					end
					seq_reset: begin
						if (tck_fall) begin
							if (cnt == 6'(jtag_pkg::RESET_TCKS - 1)) begin
								trst_n <= 1'b1;
								tms    <= 1'b0;    // one clock into run-test/idle
								fin    <= 1'b1;
							end
							cnt <= cnt + 6'd1;
						end
					end
					seq_scan: begin
						if (tck_fall) begin
							tms <= scan_tms(state, cmd_q == jtag_pkg::cmd_scan_ir, last_bit);
							if (in_shift)
								cnt <= cnt + 6'd1;
							if (state == jtag_pkg::update_ir || state == jtag_pkg::update_dr)
								fin <= 1'b1;
						end
					end
					default: seq <= seq_idle;
				endcase
			end
		end
	end

endmodule

//--- hw/scan_shifter.sv
`timescale 1ns/1ps

module scan_shifter (
	input  logic                       tck_1,
	input  logic                       reset,
	input  logic                       start_load,
	input  logic                       tck_rise,
	input  logic                       tck_fall,
	input  logic                       shift_en,
	input  logic                       tdi,
	input  logic [jtag_pkg::SCAN_W-1:0] drv_word,
	input  logic [jtag_pkg::SCAN_W-1:0] exp_word,
	input  logic [jtag_pkg::SCAN_W-1:0] mask_word,
	output logic                       tdo,
	output logic                       fail,
	output logic [jtag_pkg::SCAN_W-1:0] capture_word
);

	localparam logic [5:0] FULL_W = 6'(jtag_pkg::SCAN_W);

	logic [jtag_pkg::SCAN_W-1:0] drv_sr;
	logic [jtag_pkg::SCAN_W-1:0] exp_sr;
	logic [jtag_pkg::SCAN_W-1:0] mask_sr;
	logic [jtag_pkg::SCAN_W-1:0] cap_sr;
	logic [5:0]                  nbits;    // bits sampled so far

	// tdi enters at the top so the first bit lands at bit 0
	assign capture_word = cap_sr >> (FULL_W - nbits);

	always_ff @(posedge tck_1) begin
		if (!reset) begin
			tdo   <= 1'b0;
			fail  <= 1'b0;
			nbits <= '0;
		end else if (start_load) begin
			drv_sr  <= drv_word;
			exp_sr  <= exp_word;
			mask_sr <= mask_word;
			cap_sr  <= '0;
			nbits   <= '0;
			fail    <= 1'b0;
		end else if (shift_en) begin
			if (tck_fall) begin
				tdo    <= drv_sr[0];    // lsb first
				drv_sr <= drv_sr >> 1;
			end
			if (tck_rise) begin
				cap_sr  <= {tdi, cap_sr[jtag_pkg::SCAN_W-1:1]};
				fail    <= fail | (mask_sr[0] & (exp_sr[0] ^ tdi));    // sticky
				exp_sr  <= exp_sr >> 1;
				mask_sr <= mask_sr >> 1;
				nbits   <= nbits + 6'd1;
			end
		end
	end

endmodule

//--- hw/jtag_master.sv
`timescale 1ns/1ps

module jtag_master #(
	parameter int TCK_DIV = 2
) (
	input  logic                        tck_1,
	input  logic                        reset,
	input  logic                        cmd_start,
	input  jtag_pkg::jtag_cmd_t         cmd,
	input  logic [5:0]                  scan_len,
	input  logic [jtag_pkg::SCAN_W-1:0] drv_word,
	input  logic [jtag_pkg::SCAN_W-1:0] exp_word,
	input  logic [jtag_pkg::SCAN_W-1:0] mask_word,
	input  logic                        tap_tdi,
	output logic                        tap_tck,
	output logic                        tap_tms,
	output logic                        tap_tdo,
	output logic                        tap_trst_n,
	output logic                        busy,
	output logic                        done,
	output logic                        fail,
	output logic [jtag_pkg::SCAN_W-1:0] capture_word,
	output jtag_pkg::tap_state_t        tap_state
);

	logic run;
	logic tck_rise;
	logic tck_fall;
	logic shift_en;
	logic start_load;

	////////////////////////////////////////////////////////////////////////////
	// clock, tap view, command control and data path
	////////////////////////////////////////////////////////////////////////////

	tck_gen #(.TCK_DIV(TCK_DIV)) i_tck_gen (
		.tck_1   (tck_1),
		.reset   (reset),
		.run     (run),
		.tap_tck (tap_tck),
		.tck_rise(tck_rise),
		.tck_fall(tck_fall)
	);

	tap_state_tracker i_tracker (
		.tck_1   (tck_1),
		.reset   (reset),
		.tck_rise(tck_rise),
		.tms     (tap_tms),
		.state   (tap_state)
	);

	tap_sequencer i_sequencer (
		.tck_1     (tck_1),
		.reset     (reset),
		.cmd_start (cmd_start),
		.cmd       (cmd),
		.scan_len  (scan_len),
		.tck_fall  (tck_fall),
		.state     (tap_state),
		.run       (run),
		.tms       (tap_tms),
		.trst_n    (tap_trst_n),
		.shift_en  (shift_en),
		.start_load(start_load),
		.busy      (busy),
		.done      (done)
	);

	scan_shifter i_shifter (
		.tck_1       (tck_1),
		.reset       (reset),
		.start_load  (start_load),
		.tck_rise    (tck_rise),
		.tck_fall    (tck_fall),
		.shift_en    (shift_en),
		.tdi         (tap_tdi),
		.drv_word    (drv_word),
		.exp_word    (exp_word),
		.mask_word   (mask_word),
		.tdo         (tap_tdo),
		.fail        (fail),
		.capture_word(capture_word)
	);

endmodule

//--- dv/tap_target_model.sv
`timescale 1ns/1ps

module tap_target_model (
	input  logic                 tap_tck,
	input  logic                 tap_tms,
	input  logic                 tap_tdo,       // master tdo is the target tdi
	input  logic                 tap_trst_n,
	input  logic [31:0]          dr_capture,
	output logic                 tap_tdi,
	output logic [3:0]           ir_reg,
	output logic [31:0]          dr_reg,
	output jtag_pkg::tap_state_t state
);

	// 1149.1 transitions with tms taken at the tck rise
	function automatic jtag_pkg::tap_state_t next_tap_state(jtag_pkg::tap_state_t s, logic tms);
		case (s)
			jtag_pkg::test_logic_reset: return tms ? s : jtag_pkg::run_test_idle;
			jtag_pkg::run_test_idle:    return tms ? jtag_pkg::select_dr_scan : s;
			jtag_pkg::select_dr_scan:
				return tms ? jtag_pkg::select_ir_scan : jtag_pkg::capture_dr;
			jtag_pkg::select_ir_scan:
				return tms ? jtag_pkg::test_logic_reset : jtag_pkg::capture_ir;
			jtag_pkg::capture_dr, jtag_pkg::shift_dr:
				return tms ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
			jtag_pkg::exit1_dr: return tms ? jtag_pkg::update_dr : jtag_pkg::pause_dr;
			jtag_pkg::pause_dr: return tms ? jtag_pkg::exit2_dr : s;
			jtag_pkg::exit2_dr: return tms ? jtag_pkg::update_dr : jtag_pkg::shift_dr;
			jtag_pkg::capture_ir, jtag_pkg::shift_ir:
				return tms ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
			jtag_pkg::exit1_ir: return tms ? jtag_pkg::update_ir : jtag_pkg::pause_ir;
			jtag_pkg::pause_ir: return tms ? jtag_pkg::exit2_ir : s;
			jtag_pkg::exit2_ir: return tms ? jtag_pkg::update_ir : jtag_pkg::shift_ir;
			jtag_pkg::update_dr, jtag_pkg::update_ir:
				return tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
			default: return jtag_pkg::test_logic_reset;
		endcase
	endfunction

	initial begin
		state   = jtag_pkg::test_logic_reset;
		tap_tdi = 1'b0;
		ir_reg  = '0;
		dr_reg  = '0;
	end

	// capture and shift act on the state before the rise
	always @(posedge tap_tck or negedge tap_trst_n) begin
		if (!tap_trst_n) begin
			state <= jtag_pkg::test_logic_reset;
		end else begin
			case (state)
				jtag_pkg::capture_ir: ir_reg <= 4'b0101;
				jtag_pkg::shift_ir:   ir_reg <= {tap_tdo, ir_reg[3:1]};
				default: ;
			endcase
			if (state == jtag_pkg::capture_dr)
				dr_reg <= dr_capture;
			else if (state == jtag_pkg::shift_dr)
				dr_reg <= {tap_tdo, dr_reg[31:1]};    // enters at the top
			state <= next_tap_state(state, tap_tms);
		end
	end

	always @(negedge tap_tck) begin
		if (state == jtag_pkg::shift_ir)
			tap_tdi <= ir_reg[0];
		else if (state == jtag_pkg::shift_dr)
			tap_tdi <= dr_reg[0];
		else
			tap_tdi <= 1'b0;
	end

endmodule

//--- dv/tb_jtag_master.sv
`timescale 1ns/1ps

module tb_jtag_master;

	localparam int TCK_DIV      = 2;
	localparam int CLK_NS       = 8;
	localparam int TCKS_PER_CMD = 40;    // 32-bit ir scan from reset is 39 tap clocks
	localparam int NUM_CMDS     = 8;
	localparam int CMD_CYCLES   = TCKS_PER_CMD * 2 * TCK_DIV;
	localparam int TIMEOUT_NS   = CMD_CYCLES * NUM_CMDS * CLK_NS;

	logic                 tck_1;
	logic                 reset;
	logic                 cmd_start;
	jtag_pkg::jtag_cmd_t  cmd;
	logic [5:0]           scan_len;
	logic [31:0]          drv_word;
	logic [31:0]          exp_word;
	logic [31:0]          mask_word;
	logic                 tap_tdi;
	logic                 tap_tck;
	logic                 tap_tms;
	logic                 tap_tdo;
	logic                 tap_trst_n;
	logic                 busy;
	logic                 done;
	logic                 fail;
	logic [31:0]          capture_word;
	jtag_pkg::tap_state_t tap_state;
	logic [31:0]          target_word;      // model capture-dr value
	logic [3:0]           ir_reg;
	logic [31:0]          dr_reg;
	jtag_pkg::tap_state_t target_state;
	logic                 trst_low_seen;

	jtag_master #(.TCK_DIV(TCK_DIV)) i_dut (.*);

	tap_target_model i_target (
		.tap_tck   (tap_tck),
		.tap_tms   (tap_tms),
		.tap_tdo   (tap_tdo),
		.tap_trst_n(tap_trst_n),
		.dr_capture(target_word),
		.tap_tdi   (tap_tdi),
		.ir_reg    (ir_reg),
		.dr_reg    (dr_reg),
		.state     (target_state)
	);

	initial begin
		tck_1 = 1'b0;
		forever #(CLK_NS / 2) tck_1 = ~tck_1;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns with tests still running", TIMEOUT_NS);
		$display("Simulation failed");
		$fatal(1, "watchdog timeout");
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(string test, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected) else
			abort_run($sformatf("FAIL %s: expected %h, actual %h", test, expected, actual));
	endtask

	function automatic logic [31:0] low_bits(logic [31:0] w, int len);
		return (len >= 32) ? w : (w & ((32'd1 << len) - 32'd1));
	endfunction

	// any masked bit below len that differs
	function automatic logic expected_fail(logic [31:0] expv, logic [31:0] cap,
			logic [31:0] mask, int len);
		logic f;
		f = 1'b0;
		for (int i = 0; i < len; i++)
			f |= mask[i] & (expv[i] != cap[i]);
		return f;
	endfunction

	task automatic start_command(jtag_pkg::jtag_cmd_t c, logic [5:0] len,
			logic [31:0] drv, logic [31:0] expv, logic [31:0] mask);
		@(posedge tck_1);
		cmd_start <= 1'b1;
		cmd       <= c;
		scan_len  <= len;
		drv_word  <= drv;
		exp_word  <= expv;
		mask_word <= mask;
		@(posedge tck_1);
		cmd_start <= 1'b0;
	endtask

	task automatic wait_for_done(string test);
		int   n;
		logic got;
		n = 0;
		got = 1'b0;
		trst_low_seen = 1'b0;
		while (!got) begin
			@(posedge tck_1);
			if (busy && !tap_trst_n) begin
				trst_low_seen = 1'b1;
				check_word(test, 32'd1, 32'(tap_tms));    // tms held high in reset
			end
			got = done;
			n++;
			check_word(test, 32'(!got), 32'(busy));    // busy drops with done
			assert (got || n < CMD_CYCLES) else
				abort_run($sformatf("%s: no done pulse within %0d cycles", test, CMD_CYCLES));
		end
	endtask

	task automatic scan_and_check(string test, jtag_pkg::jtag_cmd_t c, int len,
			logic [31:0] drv, logic [31:0] cap, logic [31:0] expv, logic [31:0] mask);
		logic [31:0] rx;
		if (c == jtag_pkg::cmd_scan_dr)
			target_word = cap;
		start_command(c, 6'(len), drv, expv, mask);
		wait_for_done(test);
		rx = (c == jtag_pkg::cmd_scan_ir) ? 32'(ir_reg) : dr_reg >> (32 - len);
		check_word(test, low_bits(cap, len), capture_word);
		check_word(test, 32'(expected_fail(expv, cap, mask, len)), 32'(fail));
		check_word(test, low_bits(drv, len), rx);    // what the target received
		check_word(test, 32'(jtag_pkg::run_test_idle), 32'(target_state));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_reset_seq();
		start_command(jtag_pkg::cmd_bus_reset, 6'd0, '0, '0, '0);
		wait_for_done("bus_reset");
		assert (trst_low_seen) else
			abort_run("bus_reset: tap_trst_n never went low while busy");
		check_word("bus_reset", 32'(jtag_pkg::run_test_idle), 32'(tap_state));
		check_word("bus_reset", 32'(jtag_pkg::run_test_idle), 32'(target_state));
	endtask

	task automatic ir_scan_len4();
		scan_and_check("ir_scan", jtag_pkg::cmd_scan_ir, 4, $urandom, 32'h5, 32'h5, 32'hF);
	endtask

	task automatic dr_scan_full();
		logic [31:0] cap;
		cap = $urandom;
		scan_and_check("dr_scan_32", jtag_pkg::cmd_scan_dr, 32, $urandom, cap, cap, '1);
		check_word("dr_scan_32", 32'd0, 32'(fail));
	endtask

	task automatic masked_compare();
		logic [31:0] drv;
		logic [31:0] cap;
		logic [31:0] flip;
		drv = $urandom;
		cap = $urandom;
		flip = 32'd1 << ($urandom % 32);
		scan_and_check("masked_hit", jtag_pkg::cmd_scan_dr, 32, drv, cap, cap ^ flip, '1);
		check_word("masked_hit", 32'd1, 32'(fail));
		scan_and_check("masked_off", jtag_pkg::cmd_scan_dr, 32, drv, cap, cap ^ flip, ~flip);
		check_word("masked_off", 32'd0, 32'(fail));
		scan_and_check("short_dr", jtag_pkg::cmd_scan_dr, 7, drv, cap, cap, '1);
		check_word("short_dr", 32'd0, capture_word >> 7);    // nothing above scan_len
	endtask

	task automatic ignored_start();
		int          dones;
		logic [31:0] cap;
		cap = $urandom;
		target_word = cap;
		start_command(jtag_pkg::cmd_scan_dr, 6'd8, 32'hA5, cap, '1);
		repeat (2) @(posedge tck_1);
		cmd_start <= 1'b1;    // arrives while busy
		cmd       <= jtag_pkg::cmd_scan_ir;
		scan_len  <= 6'd4;
		drv_word  <= 32'h5A;
		exp_word  <= ~cap;
		@(posedge tck_1);
		cmd_start <= 1'b0;
		wait_for_done("ignored_start");
		dones = 1;
		repeat (20) begin
			@(posedge tck_1);
			if (done)
				dones++;
			check_word("idle_tck", 32'd0, 32'(tap_tck));
		end
		check_word("ignored_start", 32'd1, 32'(dones));
		check_word("ignored_start", low_bits(cap, 8), capture_word);
		check_word("ignored_start", 32'd0, 32'(fail));
		check_word("ignored_start", 32'hA5, dr_reg >> 24);    // first drive word kept
	endtask

	initial begin
		void'($urandom(32'h66a2));
		reset         = 1'b0;
		cmd_start     = 1'b0;
		cmd           = jtag_pkg::cmd_bus_reset;
		scan_len      = '0;
		drv_word      = '0;
		exp_word      = '0;
		mask_word     = '0;
		target_word   = '0;
		trst_low_seen = 1'b0;
		repeat (2) @(posedge tck_1);
		reset <= 1'b1;
		bus_reset_seq();
		ir_scan_len4();
		dr_scan_full();
		masked_compare();
		ignored_start();
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- compile.f
hw/jtag_pkg.sv
hw/tck_gen.sv
hw/tap_state_tracker.sv
hw/tap_sequencer.sv
hw/scan_shifter.sv
hw/jtag_master.sv
dv/tap_target_model.sv
dv/tb_jtag_master.sv

//--- Bender.yml
package:
  name: jtag_master

sources:
  - hw/jtag_pkg.sv
  - hw/tck_gen.sv
  - hw/tap_state_tracker.sv
  - hw/tap_sequencer.sv
  - hw/scan_shifter.sv
  - hw/jtag_master.sv
  - target: test
    files:
      - dv/tap_target_model.sv
      - dv/tb_jtag_master.sv
